// ==== mmc_pkg.sv ====
/*
 Shared definitions for the SPI-mode MMC/SD block device.
 A block is 512 bytes and travels as 256 words, low byte first.
*/
package mmc_pkg;

   // host command codes
   typedef enum logic [1:0] {
      bd_reset = 2'b00,
      bd_read  = 2'b01,
      bd_write = 2'b10,
      bd_none  = 2'b11
   } bd_cmd_t;

   typedef enum logic [5:0] {
      cmd_go_idle      = 6'd0,
      cmd_send_op      = 6'd1,
      cmd_set_blocklen = 6'd16,
      cmd_read_single  = 6'd17,
      cmd_write_single = 6'd24
   } mmc_cmd_index_t;

   // R1 reply, msb first on the wire
   typedef struct packed {
      logic start;
      logic param_err;
      logic addr_err;
      logic erase_seq_err;
      logic crc_err;
      logic illegal_cmd;
      logic erase_reset;
      logic idle;
   } mmc_r1_t;

   // data response token after a write block
   typedef struct packed {
      logic [2:0] unused;
      logic       zero;
      logic [2:0] status;
      logic       end_bit;
   } mmc_dresp_t;

   typedef union packed {
      mmc_r1_t    r1;
      mmc_dresp_t dresp;
   } mmc_resp_u;

   localparam logic [7:0] token_start_block = 8'hfe;
   localparam logic [2:0] dresp_accepted    = 3'b010;

   localparam int frame_bytes     = 6;
   // 80 idle clocks with CS high at power-up
   localparam int power_up_bytes  = 10;
   localparam int block_bytes     = 512;
   localparam int words_per_block = block_bytes / 2;

endpackage

// ==== mmc_byte_if.sv ====
/*
 Byte handshake between the block sequencer and the SPI engine.
 op_valid is held with its data until op_done, then dropped for a cycle.
*/
interface mmc_byte_if;

   logic       op_valid;
   // 0 transfers tx_byte, 1 raises CS and clocks 8 idle bits
   logic       op_kind;
   logic [7:0] tx_byte;
   logic       op_done;
   // valid with op_done
   logic [7:0] rx_byte;

   modport ctrl (
      output op_valid,
      output op_kind,
      output tx_byte,
      input  op_done,
      input  rx_byte
   );

   modport phy (
      input  op_valid,
      input  op_kind,
      input  tx_byte,
      output op_done,
      output rx_byte
   );

endinterface

// ==== mmc_spi_byte.sv ====
/*
 SPI mode 0 byte engine, msb first. SCLK half period is clk_div clocks.
 CS falls with a transfer and rises only with a release.
*/
module mmc_spi_byte #(
   parameter int clk_div = 2
) (
   input  logic    clk,
   input  logic    reset,
   mmc_byte_if.phy bus,
   input  logic    mmc_di,
   output logic    mmc_do,
   output logic    mmc_cs,
   output logic    mmc_sclk
);

   localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

   logic             busy;
   logic             done;
   logic             accept;
   logic             tick;
   logic [div_w-1:0] div_cnt;
   logic [3:0]       half_cnt;
   logic [7:0]       tx_sh;
   logic [7:0]       rx_sh;

   // no new op in the done cycle, op_valid is still up then
   assign accept = !busy && bus.op_valid && !done;
   assign tick   = (div_cnt == div_w'(clk_div - 1));

   assign bus.op_done = done;
   assign bus.rx_byte = rx_sh;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy     <= 1'b0;
         done     <= 1'b0;
         div_cnt  <= '0;
         half_cnt <= '0;
         mmc_cs   <= 1'b1;
         mmc_sclk <= 1'b0;
         mmc_do   <= 1'b1;
      end
      else
      begin
         done <= 1'b0;
         if (accept)
         begin
            busy     <= 1'b1;
            div_cnt  <= '0;
            half_cnt <= '0;
            mmc_cs   <= bus.op_kind;
            mmc_do   <= bus.op_kind ? 1'b1 : bus.tx_byte[7];
         end
         else if (busy && tick)
         begin
            div_cnt  <= '0;
            mmc_sclk <= ~mmc_sclk;
            half_cnt <= half_cnt + 4'd1;
            // next bit goes out on the falling edge
            if (mmc_sclk)
               mmc_do <= tx_sh[6];
            if (half_cnt == 4'd15)
            begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
         else if (busy)
            div_cnt <= div_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         tx_sh <= bus.op_kind ? 8'hff : bus.tx_byte;
      else if (busy && tick && mmc_sclk)
         tx_sh <= {tx_sh[6:0], 1'b1};
      // sample on the rising edge
      if (busy && tick && !mmc_sclk)
         rx_sh <= {rx_sh[6:0], mmc_di};
   end

   // request held steady until its op_done
   assert property (@(posedge clk) disable iff (reset)
      bus.op_valid && !bus.op_done
      |=> bus.op_valid && $stable(bus.op_kind) && $stable(bus.tx_byte));

endmodule

// ==== mmc_word_fifo.sv ====
/*
 Synchronous FIFO of 2**addr_bits 16-bit words.
 pop_data shows the head word before the pop.
 Push when full and pop when empty are not allowed.
*/
module mmc_word_fifo #(
   parameter int addr_bits = 4
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        push,
   input  logic [15:0] push_data,
   output logic        full,
   input  logic        pop,
   output logic [15:0] pop_data,
   output logic        empty
);

   localparam int depth = 2 ** addr_bits;

   logic [15:0]          mem [depth];
   logic [addr_bits-1:0] wr_ptr;
   logic [addr_bits-1:0] rd_ptr;
   logic [addr_bits:0]   count;

   assign pop_data = mem[rd_ptr];
   assign empty    = (count == '0);
   assign full     = (count == (addr_bits + 1)'(depth));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   assert property (@(posedge clk) disable iff (reset) push |-> !full);
   assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== mmc_block_ctrl.sv ====
/*
 MMC/SD command sequencer in SPI mode, one 512-byte block per command.
 CRC is not checked. A read or write before any reset runs card init first.
 err holds until the next accepted start.
*/
module mmc_block_ctrl (
   input  logic             clk,
   input  logic             reset,
   input  mmc_pkg::bd_cmd_t cmd,
   input  logic             start,
   input  logic [22:0]      addr,
   output logic             bsy,
   output logic             err,
   mmc_byte_if.ctrl         bus,
   output logic             rf_push,
   output logic [15:0]      rf_data,
   input  logic             rf_full,
   output logic             wf_pop,
   input  logic [15:0]      wf_data,
   input  logic             wf_empty
);

   import mmc_pkg::*;

   localparam logic [3:0]
      s_idle     = 4'd0,
      s_power    = 4'd1,
      s_frame    = 4'd2,
      s_r1       = 4'd3,
      s_rd_token = 4'd4,
      s_rd_lo    = 4'd5,
      s_rd_hi    = 4'd6,
      s_rd_crc   = 4'd7,
      s_wr_token = 4'd8,
      s_wr_lo    = 4'd9,
      s_wr_hi    = 4'd10,
      s_wr_crc   = 4'd11,
      s_wr_dresp = 4'd12,
      s_wr_busy  = 4'd13,
      s_release  = 4'd14,
      s_done     = 4'd15;

   logic [3:0]     state;
   logic [3:0]     rel_next;
   bd_cmd_t        cmd_hold;
   mmc_cmd_index_t cur_idx;
   logic [31:0]    byte_addr;
   logic           inited;
   logic [3:0]     cnt;
   logic [7:0]     word_cnt;
   logic [7:0]     lo_byte;
   logic           byte_gap;
   logic           want;
   logic           last_word;
   mmc_resp_u      resp;
   logic [31:0]    cmd_arg;
   logic [47:0]    frame;
   logic [7:0]     frame_byte;

   assign resp      = bus.rx_byte;
   assign bsy       = (state != s_idle);
   assign last_word = (word_cnt == 8'(words_per_block - 1));

   assign rf_push = (state == s_rd_hi) && bus.op_done;
   assign rf_data = {bus.rx_byte, lo_byte};
   assign wf_pop  = (state == s_wr_hi) && bus.op_done;

   // one idle cycle after each op_done
   assign bus.op_valid = want && !byte_gap;

   always_comb
   begin
      case (cur_idx)
         cmd_read_single, cmd_write_single: cmd_arg = byte_addr;
         cmd_set_blocklen:                  cmd_arg = 32'(block_bytes);
         default:                           cmd_arg = '0;
      endcase
      frame = {2'b01, cur_idx, cmd_arg, (cur_idx == cmd_go_idle) ? 8'h95 : 8'h01};
      case (cnt[2:0])
         3'd0:    frame_byte = frame[47:40];
         3'd1:    frame_byte = frame[39:32];
         3'd2:    frame_byte = frame[31:24];
         3'd3:    frame_byte = frame[23:16];
         3'd4:    frame_byte = frame[15:8];
         default: frame_byte = frame[7:0];
      endcase
   end

   always_comb
   begin
      want        = 1'b1;
      bus.op_kind = 1'b0;
      bus.tx_byte = 8'hff;
      case (state)
         s_idle, s_done: want = 1'b0;
         s_power, s_release: bus.op_kind = 1'b1;
         s_frame: bus.tx_byte = frame_byte;
         // stall SCLK until there is room for a whole word
         s_rd_lo: want = !rf_full;
         s_wr_token: bus.tx_byte = token_start_block;
         s_wr_lo:
         begin
            want        = !wf_empty;
            bus.tx_byte = wf_data[7:0];
         end
         s_wr_hi: bus.tx_byte = wf_data[15:8];
         default: want = 1'b1;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (state == s_idle && start)
         byte_addr <= {addr, 9'b0};
      if (state == s_rd_lo && bus.op_done)
         lo_byte <= bus.rx_byte;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= s_idle;
         rel_next <= s_idle;
         cmd_hold <= bd_none;
         cur_idx  <= cmd_go_idle;
         inited   <= 1'b0;
         err      <= 1'b0;
         cnt      <= '0;
         word_cnt <= '0;
         byte_gap <= 1'b0;
      end
      else
      begin
         byte_gap <= bus.op_done;
         case (state)
            s_idle:
               if (start)
               begin
                  cmd_hold <= cmd;
                  err      <= 1'b0;
                  cnt      <= '0;
                  cur_idx  <= (cmd == bd_write) ? cmd_write_single : cmd_read_single;
                  case (cmd)
                     bd_reset:          state <= s_power;
                     bd_read, bd_write: state <= inited ? s_frame : s_power;
                     default:           state <= s_done;
                  endcase
               end
            s_power:
               if (bus.op_done)
               begin
                  cnt <= cnt + 4'd1;
                  if (cnt == 4'(power_up_bytes - 1))
                  begin
                     cnt     <= '0;
                     cur_idx <= cmd_go_idle;
                     state   <= s_frame;
                  end
               end
            s_frame:
               if (bus.op_done)
               begin
                  cnt <= cnt + 4'd1;
                  if (cnt == 4'(frame_bytes - 1))
                  begin
                     cnt   <= '0;
                     state <= s_r1;
                  end
               end
            // poll until the start bit clears
            s_r1:
               if (bus.op_done && !resp.r1.start)
               begin
                  state    <= s_release;
                  rel_next <= s_idle;
                  case (cur_idx)
                     cmd_go_idle:
                        if (bus.rx_byte == 8'h01)
                        begin
                           cur_idx  <= cmd_send_op;
                           rel_next <= s_frame;
                        end
                        else
                           err <= 1'b1;
                     cmd_send_op:
                        if (bus.rx_byte == 8'h00)
                        begin
                           cur_idx  <= cmd_set_blocklen;
                           rel_next <= s_frame;
                        end
                        else if (resp.r1.idle && bus.rx_byte[7:1] == 7'd0)
                           rel_next <= s_frame;
                        else
                           err <= 1'b1;
                     cmd_set_blocklen:
                        if (bus.rx_byte == 8'h00)
                        begin
                           inited <= 1'b1;
                           // automatic init goes on to the block command
                           if (cmd_hold != bd_reset)
                           begin
                              cur_idx  <= (cmd_hold == bd_write) ? cmd_write_single
                                                                 : cmd_read_single;
                              rel_next <= s_frame;
                           end
                        end
                        else
                           err <= 1'b1;
                     default:
                        if (bus.rx_byte == 8'h00)
                           state <= (cur_idx == cmd_write_single) ? s_wr_token : s_rd_token;
                        else
                           err <= 1'b1;
                  endcase
               end
            s_rd_token:
               if (bus.op_done)
               begin
                  word_cnt <= '0;
                  if (bus.rx_byte == token_start_block)
                     state <= s_rd_lo;
                  else if (bus.rx_byte != 8'hff)
                  begin
                     err      <= 1'b1;
                     rel_next <= s_idle;
                     state    <= s_release;
                  end
               end
            s_rd_lo, s_wr_lo:
               if (bus.op_done)
                  state <= (state == s_rd_lo) ? s_rd_hi : s_wr_hi;
            s_rd_hi, s_wr_hi:
               if (bus.op_done)
               begin
                  word_cnt <= word_cnt + 8'd1;
                  cnt      <= '0;
                  if (state == s_rd_hi)
                     state <= last_word ? s_rd_crc : s_rd_lo;
                  else
                     state <= last_word ? s_wr_crc : s_wr_lo;
               end
            s_rd_crc:
               if (bus.op_done)
               begin
                  cnt <= cnt + 4'd1;
                  if (cnt == 4'd1)
                  begin
                     rel_next <= s_idle;
                     state    <= s_release;
                  end
               end
            s_wr_token:
               if (bus.op_done)
               begin
                  word_cnt <= '0;
                  state    <= s_wr_lo;
               end
            s_wr_crc:
               if (bus.op_done)
               begin
                  cnt <= cnt + 4'd1;
                  if (cnt == 4'd1)
                     state <= s_wr_dresp;
               end
            s_wr_dresp:
               if (bus.op_done && !resp.dresp.zero && resp.dresp.end_bit)
               begin
                  if (resp.dresp.status != dresp_accepted)
                     err <= 1'b1;
                  state <= s_wr_busy;
               end
            // card holds the line low while programming
            s_wr_busy:
               if (bus.op_done && bus.rx_byte != 8'h00)
               begin
                  rel_next <= s_idle;
                  state    <= s_release;
               end
            s_release:
               if (bus.op_done)
               begin
                  cnt   <= '0;
                  state <= rel_next;
               end
            default: state <= s_idle;
         endcase
      end
   end

   // a begun byte pair never overruns or underruns its FIFO
   assert property (@(posedge clk) disable iff (reset)
      state == s_rd_hi |-> !rf_full);
   assert property (@(posedge clk) disable iff (reset)
      state == s_wr_hi |-> !wf_empty);

endmodule

// ==== mmc_block_dev.sv ====
/*
 SPI MMC/SD block device with a 16-bit host word port.
 One 512-byte block per read or write, words packed low byte first.
 FIFOs hold 2**fifo_addr_bits words; SCLK stalls when they block.
*/
module mmc_block_dev #(
   parameter int clk_div        = 2,
   parameter int fifo_addr_bits = 4
) (
   input  logic             clk,
   input  logic             reset,
   input  mmc_pkg::bd_cmd_t cmd,
   input  logic             start,
   input  logic [22:0]      addr,
   output logic             bsy,
   output logic             rdy,
   output logic             err,
   output logic             iordy,
   input  logic [15:0]      data_in,
   output logic [15:0]      data_out,
   input  logic             rd,
   input  logic             wr,
   output logic             mmc_cs,
   output logic             mmc_do,
   output logic             mmc_sclk,
   input  logic             mmc_di
);

   logic        rf_push;
   logic [15:0] rf_data;
   logic        rf_full;
   logic        rf_empty;
   logic        wf_pop;
   logic [15:0] wf_data;
   logic        wf_full;
   logic        wf_empty;

   mmc_byte_if byte_bus ();

   assign rdy   = !wf_full;
   assign iordy = !rf_empty;

   mmc_block_ctrl u_ctrl (
      .clk      (clk),
      .reset    (reset),
      .cmd      (cmd),
      .start    (start),
      .addr     (addr),
      .bsy      (bsy),
      .err      (err),
      .bus      (byte_bus.ctrl),
      .rf_push  (rf_push),
      .rf_data  (rf_data),
      .rf_full  (rf_full),
      .wf_pop   (wf_pop),
      .wf_data  (wf_data),
      .wf_empty (wf_empty)
   );

   mmc_spi_byte #(
      .clk_div (clk_div)
   ) u_spi (
      .clk      (clk),
      .reset    (reset),
      .bus      (byte_bus.phy),
      .mmc_di   (mmc_di),
      .mmc_do   (mmc_do),
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk)
   );

   // card to host
   mmc_word_fifo #(
      .addr_bits (fifo_addr_bits)
   ) u_read_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (rf_push),
      .push_data (rf_data),
      .full      (rf_full),
      .pop       (rd),
      .pop_data  (data_out),
      .empty     (rf_empty)
   );

   // host to card
   mmc_word_fifo #(
      .addr_bits (fifo_addr_bits)
   ) u_write_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (wr),
      .push_data (data_in),
      .full      (wf_full),
      .pop       (wf_pop),
      .pop_data  (wf_data),
      .empty     (wf_empty)
   );

endmodule

// ==== tb_mmc_card.sv ====
/*
 Behavioral SPI mode 0 card for simulation only. 8 blocks of 512 bytes.
 CRC is ignored. CMD1 answers idle twice after each CMD0.
 fault_r1 rejects CMD17/CMD24, fault_dresp rejects the data block.
*/
module tb_mmc_card (
   input  logic mmc_cs,
   input  logic mmc_sclk,
   input  logic mmc_do,
   output logic mmc_di,
   input  logic fault_r1,
   input  logic fault_dresp
);

   timeunit 1ns;
   timeprecision 100ps;

   import mmc_pkg::*;

   localparam int wr_none  = 0;
   localparam int wr_token = 1;
   localparam int wr_data  = 2;

   logic [7:0] mem [8 * block_bytes];
   logic [5:0] cmd_log [$];
   logic [7:0] tx_q [$];
   logic [7:0] frame [frame_bytes];
   logic [7:0] rx_sh;
   logic [7:0] tx_sh;
   logic [2:0] bit_cnt;
   int         frame_cnt;
   int         data_cnt;
   int         op_cnt;
   int         wr_state;
   int         wr_base;

   function automatic int log_count();
      return cmd_log.size();
   endfunction

   function automatic logic [5:0] log_entry(int i);
      return cmd_log[i];
   endfunction

   function automatic logic [7:0] mem_byte(int i);
      return mem[i];
   endfunction

   task automatic run_command();
      logic [5:0]  idx;
      logic [31:0] arg;
      int          base;
      idx  = frame[0][5:0];
      arg  = {frame[1], frame[2], frame[3], frame[4]};
      base = int'(arg[11:9]) * block_bytes;
      cmd_log.push_back(idx);
      // one byte of Ncr before R1
      tx_q.push_back(8'hff);
      case (idx)
         6'd0:
         begin
            op_cnt = 0;
            tx_q.push_back(8'h01);
         end
         6'd1:
         begin
            op_cnt++;
            tx_q.push_back((op_cnt < 3) ? 8'h01 : 8'h00);
         end
         6'd16: tx_q.push_back(8'h00);
         6'd17:
            if (fault_r1)
               tx_q.push_back(8'h04);
            else
            begin
               tx_q.push_back(8'h00);
               repeat (3) tx_q.push_back(8'hff);
               tx_q.push_back(token_start_block);
               for (int i = 0; i < block_bytes; i++)
                  tx_q.push_back(mem[base + i]);
               tx_q.push_back(8'h5a);
               tx_q.push_back(8'h3c);
            end
         6'd24:
            if (fault_r1)
               tx_q.push_back(8'h04);
            else
            begin
               tx_q.push_back(8'h00);
               wr_state = wr_token;
               wr_base  = base;
            end
         default: tx_q.push_back(8'h04);
      endcase
   endtask

   task automatic take_byte(logic [7:0] b);
      if (wr_state == wr_token)
      begin
         if (b == token_start_block)
         begin
            wr_state = wr_data;
            data_cnt = 0;
         end
      end
      else if (wr_state == wr_data)
      begin
         // rejected blocks are not stored
         if (data_cnt < block_bytes && !fault_dresp)
            mem[wr_base + data_cnt] = b;
         data_cnt++;
         if (data_cnt == block_bytes + 2)
         begin
            wr_state = wr_none;
            tx_q.push_back(fault_dresp ? 8'h0d : 8'h05);
            repeat (3) tx_q.push_back(8'h00);
         end
      end
      else if (frame_cnt > 0 || b[7:6] == 2'b01)
      begin
         frame[frame_cnt] = b;
         frame_cnt++;
         if (frame_cnt == frame_bytes)
         begin
            frame_cnt = 0;
            run_command();
         end
      end
   endtask

   initial
   begin
      mmc_di    = 1'b1;
      tx_sh     = 8'hff;
      rx_sh     = 8'hff;
      bit_cnt   = '0;
      frame_cnt = 0;
      data_cnt  = 0;
      op_cnt    = 0;
      wr_state  = wr_none;
      wr_base   = 0;
      for (int i = 0; i < 8 * block_bytes; i++)
         mem[i] = 8'(i ^ (i >> 8));
   end

   always @(posedge mmc_sclk)
   begin
      if (mmc_cs)
      begin
         bit_cnt   = '0;
         frame_cnt = 0;
         wr_state  = wr_none;
         tx_sh     = 8'hff;
         tx_q.delete();
      end
      else
      begin
         rx_sh   = {rx_sh[6:0], mmc_do};
         bit_cnt = bit_cnt + 3'd1;
         if (bit_cnt == 3'd0)
         begin
            take_byte(rx_sh);
            tx_sh = (tx_q.size() > 0) ? tx_q.pop_front() : 8'hff;
         end
      end
   end

   // next bit goes out on the falling edge
   always @(negedge mmc_sclk)
      mmc_di = mmc_cs ? 1'b1 : tx_sh[~bit_cnt];

endmodule

// ==== tb_mmc_block_dev.sv ====
/*
 Testbench for the MMC block device against the behavioral card.
 Stops at the first mismatch. Slow-host rows make the FIFOs stall SCLK.
*/
module tb_mmc_block_dev;

   timeunit 1ns;
   timeprecision 100ps;

   import mmc_pkg::*;

   localparam logic [1:0] fault_none  = 2'd0;
   localparam logic [1:0] fault_r1    = 2'd1;
   localparam logic [1:0] fault_dresp = 2'd2;
   localparam int timeout_cycles = 20000;

   typedef struct packed {
      bd_cmd_t    cmd;
      logic [2:0] blk;
      logic [1:0] fault;
      logic [6:0] gap;
      logic       exp_err;
   } row_t;

   logic        clk;
   logic        reset;
   bd_cmd_t     cmd;
   logic        start;
   logic [22:0] addr;
   logic        bsy;
   logic        rdy;
   logic        err;
   logic        iordy;
   logic [15:0] data_in;
   logic [15:0] data_out;
   logic        rd;
   logic        wr;
   logic        mmc_cs;
   logic        mmc_do;
   logic        mmc_sclk;
   logic        mmc_di;
   logic        inject_r1;
   logic        inject_dresp;

   string          row_name [$];
   row_t           rows [$];
   mmc_cmd_index_t exp_log [$];
   logic [15:0]    ref_mem [8 * words_per_block];
   logic [31:0]    lfsr;
   logic           inited;

   mmc_block_dev u_dut (
      .clk      (clk),
      .reset    (reset),
      .cmd      (cmd),
      .start    (start),
      .addr     (addr),
      .bsy      (bsy),
      .rdy      (rdy),
      .err      (err),
      .iordy    (iordy),
      .data_in  (data_in),
      .data_out (data_out),
      .rd       (rd),
      .wr       (wr),
      .mmc_cs   (mmc_cs),
      .mmc_do   (mmc_do),
      .mmc_sclk (mmc_sclk),
      .mmc_di   (mmc_di)
   );

   tb_mmc_card u_card (
      .mmc_cs      (mmc_cs),
      .mmc_sclk    (mmc_sclk),
      .mmc_do      (mmc_do),
      .mmc_di      (mmc_di),
      .fault_r1    (inject_r1),
      .fault_dresp (inject_dresp)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_word(output logic [15:0] w);
      w = '0;
      for (int i = 0; i < 16; i++)
      begin
         lfsr = lfsr_step(lfsr);
         w    = {w[14:0], lfsr[0]};
      end
   endtask

   task automatic stop_with(string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
      if (act !== exp)
         stop_with($sformatf("error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_err(string name, logic exp, logic act);
      if (act !== exp)
         stop_with($sformatf("error %s: expected err %b, actual %b", name, exp, act));
   endtask

   task automatic check_cmd(string name, mmc_cmd_index_t exp, mmc_cmd_index_t act);
      if (act !== exp)
         stop_with($sformatf("error %s: expected CMD%0d, actual CMD%0d", name, exp, act));
   endtask

   task automatic add_row(string name, bd_cmd_t c, int blk, logic [1:0] fault, int gap,
                          logic exp_err);
      row_t r;
      r.cmd     = c;
      r.blk     = 3'(blk);
      r.fault   = fault;
      r.gap     = 7'(gap);
      r.exp_err = exp_err;
      row_name.push_back(name);
      rows.push_back(r);
   endtask

   task automatic wait_idle(string name);
      int n;
      n = 0;
      @(negedge clk);
      while (bsy)
      begin
         n++;
         if (n > timeout_cycles)
            stop_with($sformatf("%s: bsy did not fall in %0d cycles", name, n));
         @(negedge clk);
      end
   endtask

   task automatic issue(string name, row_t r);
      wait_idle(name);
      @(posedge clk);
      cmd          <= r.cmd;
      addr         <= 23'(r.blk);
      start        <= 1'b1;
      inject_r1    <= (r.fault == fault_r1);
      inject_dresp <= (r.fault == fault_dresp);
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      if (!bsy)
         stop_with($sformatf("%s: bsy did not rise after start", name));
   endtask

   task automatic push_word(string name, logic [15:0] w);
      int n;
      n = 0;
      @(negedge clk);
      while (!rdy)
      begin
         n++;
         if (n > timeout_cycles)
            stop_with($sformatf("%s: rdy stayed low for %0d cycles", name, n));
         @(negedge clk);
      end
      @(posedge clk);
      data_in <= w;
      wr      <= 1'b1;
      @(posedge clk);
      wr <= 1'b0;
   endtask

   task automatic pop_word(string name, output logic [15:0] w);
      int n;
      n = 0;
      @(negedge clk);
      while (!iordy)
      begin
         n++;
         if (n > timeout_cycles)
            stop_with($sformatf("%s: iordy stayed low for %0d cycles", name, n));
         @(negedge clk);
      end
      w = data_out;
      @(posedge clk);
      rd <= 1'b1;
      @(posedge clk);
      rd <= 1'b0;
   endtask

   // init runs on an explicit reset or on the first block command
   task automatic expect_log(bd_cmd_t c);
      exp_log.delete();
      if (c == bd_reset || !inited)
      begin
         exp_log.push_back(cmd_go_idle);
         repeat (3) exp_log.push_back(cmd_send_op);
         exp_log.push_back(cmd_set_blocklen);
      end
      if (c == bd_write)
         exp_log.push_back(cmd_write_single);
      else if (c == bd_read)
         exp_log.push_back(cmd_read_single);
   endtask

   task automatic run_row(int idx);
      row_t        r;
      string       name;
      int          words;
      int          base;
      int          log_pos;
      int          n_log;
      logic [15:0] w;
      logic [15:0] act;
      logic [15:0] sent [words_per_block];
      r       = rows[idx];
      name    = row_name[idx];
      words   = (r.cmd == bd_reset || r.fault == fault_r1) ? 0 : words_per_block;
      base    = int'(r.blk) * words_per_block;
      log_pos = u_card.log_count();
      expect_log(r.cmd);
      issue(name, r);
      for (int i = 0; i < words; i++)
      begin
         if (r.cmd == bd_write)
         begin
            next_word(w);
            sent[i] = w;
            push_word(name, w);
         end
         else
         begin
            pop_word(name, w);
            check_word(name, ref_mem[base + i], w);
         end
         repeat (int'(r.gap)) @(posedge clk);
      end
      wait_idle(name);
      check_err(name, r.exp_err, err);
      if (r.cmd == bd_read && iordy)
         stop_with($sformatf("%s: iordy still high after the last word", name));
      // stored bytes go low byte first
      if (r.cmd == bd_write && r.fault == fault_none)
         for (int i = 0; i < words_per_block; i++)
         begin
            act = {u_card.mem_byte(2 * (base + i) + 1), u_card.mem_byte(2 * (base + i))};
            check_word(name, sent[i], act);
            ref_mem[base + i] = sent[i];
         end
      n_log = u_card.log_count() - log_pos;
      if (n_log != exp_log.size())
         stop_with($sformatf("%s: card saw %0d commands instead of %0d", name, n_log,
                             exp_log.size()));
      for (int i = 0; i < n_log; i++)
         check_cmd(name, exp_log[i], mmc_cmd_index_t'(u_card.log_entry(log_pos + i)));
      inited = 1'b1;
   endtask

   initial
   begin
      reset        = 1'b1;
      cmd          = bd_none;
      start        = 1'b0;
      addr         = '0;
      data_in      = '0;
      rd           = 1'b0;
      wr           = 1'b0;
      inject_r1    = 1'b0;
      inject_dresp = 1'b0;
      lfsr         = 32'h498e_e0f4;
      inited       = 1'b0;

      add_row("auto_init_write", bd_write, 2, fault_none, 0, 1'b0);
      add_row("read_back", bd_read, 2, fault_none, 0, 1'b0);
      add_row("explicit_reset", bd_reset, 0, fault_none, 0, 1'b0);
      // host slower than the card
      add_row("write_slow_host", bd_write, 5, fault_none, 90, 1'b0);
      add_row("read_slow_host", bd_read, 5, fault_none, 90, 1'b0);
      add_row("read_r1_fault", bd_read, 2, fault_r1, 0, 1'b1);
      add_row("write_dresp_fault", bd_write, 3, fault_dresp, 0, 1'b1);
      add_row("clean_read", bd_read, 2, fault_none, 0, 1'b0);

      repeat (4) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < rows.size(); i++)
         run_row(i);

      $display("all tests passed");
      $finish;
   end

endmodule

// ==== sim.f ====
mmc_pkg.sv
mmc_byte_if.sv
mmc_spi_byte.sv
mmc_word_fifo.sv
mmc_block_ctrl.sv
mmc_block_dev.sv
tb_mmc_card.sv
tb_mmc_block_dev.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mmc_block_dev
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
